// File: verilog/batchEst_cfg.svh
`ifndef BATCH_EST_CFG_SVH
`define BATCH_EST_CFG_SVH

// Words per batch, power of two for {bank, index} addressing
`define BE_DEPTH 8

// Control bits per sub-sample and sub-samples per word
`define BE_M 2
`define BE_DSR 4

// Recursion value format, sign bit comes on top
`define BE_N_INT 9
`define BE_N_MANT 14

// Estimate width
`define BE_OUT_WIDTH 14

// Registers beyond the four batch periods
`define BE_PIPE 6

`endif

// File: verilog/batchEstPkg.sv
`include "batchEst_cfg.svh"

package batchEstPkg;

    typedef logic [`BE_M*`BE_DSR-1:0] sampleWord;
    typedef logic signed [`BE_N_INT+`BE_N_MANT:0] fxpValue;
    typedef logic [`BE_OUT_WIDTH-1:0] estimateWord;
    typedef logic [$clog2(`BE_DEPTH)-1:0] batchIdx;
    typedef logic [1:0] bankSel;

    typedef struct packed {
        batchIdx idx;
        batchIdx idxRev;
        bankSel writeBank;
        bankSel lookBank;
        bankSel calcBank;
        logic resBank;
        logic batchEnd;
        logic computeOn;
    } batchCtrl;

    // Bank in the upper bits
    typedef struct packed {
        bankSel bank;
        batchIdx idx;
    } memAddr;

    typedef struct packed {
        memAddr wr;
        memAddr look;
        memAddr fwd;
        memAddr bwd;
    } sampleAddrs;

    // Tap weights in recursion format, bit 0 first
    localparam fxpValue tapCoef [`BE_M*`BE_DSR] = '{
        1200, 1100, 1000, 900, 800, 700, 600, 500
    };

    // Poles, about 0.90 and 0.85
    localparam fxpValue feedForward = fxpValue'(14746);
    localparam fxpValue feedBackward = fxpValue'(13926);

    // Pole times state, rounded to nearest
    function automatic fxpValue poleProduct(fxpValue pole, fxpValue x);
        logic signed [2*$bits(fxpValue)-1:0] prod;
        prod = pole * x + (1 << (`BE_N_MANT - 1));
        return fxpValue'(prod >>> `BE_N_MANT);
    endfunction

endpackage

// File: verilog/batchControl.sv
`timescale 1ns/1ps
`include "batchEst_cfg.svh"

module batchControl (
    input  logic clkDS,
    input  logic rst,
    output batchEstPkg::batchCtrl ctrl,
    output batchEstPkg::sampleAddrs addrs,
    output logic valid
);
    import batchEstPkg::*;

    localparam int LATENCY = 4 * `BE_DEPTH + `BE_PIPE;
    localparam batchIdx LAST_IDX = batchIdx'(`BE_DEPTH - 1);
    // Batch 0 writes bank 0, look-ahead on bank 3, calculation on bank 1
    localparam batchCtrl CTRL_INIT = '{
        idx: '0, idxRev: LAST_IDX, writeBank: 2'd0, lookBank: 2'd3, calcBank: 2'd1,
        resBank: 1'b0, batchEnd: 1'b0, computeOn: 1'b0
    };

    batchCtrl ctrlNext;
    logic [$clog2(LATENCY+1)-1:0] latCnt;

    function automatic sampleAddrs addrsOf(batchCtrl c);
        sampleAddrs a;
        a.wr = '{bank: c.writeBank, idx: c.idx};
        a.look = '{bank: c.lookBank, idx: c.idxRev};
        a.fwd = '{bank: c.calcBank, idx: c.idx};
        a.bwd = '{bank: c.calcBank, idx: c.idxRev};
        return a;
    endfunction

    always_comb begin
        ctrlNext = ctrl;
        if (ctrl.batchEnd) begin
            ctrlNext.idx = '0;
            ctrlNext.idxRev = LAST_IDX;
            ctrlNext.writeBank = ctrl.writeBank + 2'd1;
            ctrlNext.lookBank = ctrl.lookBank + 2'd1;
            ctrlNext.calcBank = ctrl.calcBank + 2'd1;
            ctrlNext.resBank = ~ctrl.resBank;
            // Three batches stored once batch 2 ends
            ctrlNext.computeOn = ctrl.computeOn | (ctrl.writeBank == 2'd2);
        end else begin
            ctrlNext.idx = ctrl.idx + 1'b1;
            ctrlNext.idxRev = ctrl.idxRev - 1'b1;
        end
        ctrlNext.batchEnd = (ctrlNext.idx == LAST_IDX);
    end

    // Addresses registered together with the counters they come from
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            ctrl <= CTRL_INIT;
            addrs <= addrsOf(CTRL_INIT);
        end else begin
            ctrl <= ctrlNext;
            addrs <= addrsOf(ctrlNext);
        end
    end

    // Valid rises with the first estimate and holds
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            latCnt <= '0;
            valid <= 1'b0;
        end else if (!valid) begin
            latCnt <= latCnt + 1'b1;
            valid <= (latCnt == LATENCY - 1);
        end
    end

endmodule

// File: verilog/sampleMemory.sv
`timescale 1ns/1ps
`include "batchEst_cfg.svh"

module sampleMemory (
    input  logic clkDS,
    input  batchEstPkg::sampleAddrs addrs,
    input  batchEstPkg::sampleWord wrData,
    output batchEstPkg::sampleWord lookWord,
    output batchEstPkg::sampleWord fwdWord,
    output batchEstPkg::sampleWord bwdWord
);
    import batchEstPkg::*;

    // Four banks of one batch each
    sampleWord mem [4*`BE_DEPTH];

    // One write per cycle, no enable
    always_ff @(posedge clkDS) begin
        mem[addrs.wr] <= wrData;
    end

    // Three reads, one cycle after the address
    always_ff @(posedge clkDS) begin
        lookWord <= mem[addrs.look];
        fwdWord <= mem[addrs.fwd];
        bwdWord <= mem[addrs.bwd];
    end

endmodule

// File: verilog/lutTapSum.sv
`timescale 1ns/1ps

module lutTapSum (
    input  logic clkDS,
    input  batchEstPkg::sampleWord word,
    output batchEstPkg::fxpValue contrib
);
    import batchEstPkg::*;

    fxpValue sum;

    // A one adds its tap, a zero subtracts it
    always_comb begin
        sum = '0;
        for (int j = 0; j < $bits(sampleWord); j++) begin
            if (word[j]) begin
                sum = sum + tapCoef[j];
            end else begin
                sum = sum - tapCoef[j];
            end
        end
    end

    always_ff @(posedge clkDS) begin
        contrib <= sum;
    end

endmodule

// File: verilog/forwardRecursion.sv
`timescale 1ns/1ps

module forwardRecursion (
    input  logic clkDS,
    input  logic rst,
    input  batchEstPkg::batchCtrl ctrl,
    input  batchEstPkg::sampleWord word,
    output batchEstPkg::fxpValue result
);
    import batchEstPkg::*;

    fxpValue contrib;
    fxpValue state;
    // computeOn lined up with the tap sum
    logic [1:0] onPipe;

    lutTapSum tapSum (
        .clkDS(clkDS),
        .word(word),
        .contrib(contrib)
    );

    // State runs on across batch boundaries
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            onPipe <= '0;
            state <= '0;
        end else begin
            onPipe <= {onPipe[0], ctrl.computeOn};
            if (onPipe[1]) begin
                state <= poleProduct(feedForward, state) + contrib;
            end
        end
    end

    assign result = state;

endmodule

// File: verilog/backwardRecursion.sv
`timescale 1ns/1ps

module backwardRecursion (
    input  logic clkDS,
    input  logic rst,
    input  batchEstPkg::batchCtrl ctrl,
    input  batchEstPkg::sampleWord lookWord,
    input  batchEstPkg::sampleWord word,
    output batchEstPkg::fxpValue result
);
    import batchEstPkg::*;

    fxpValue lookContrib, calcContrib;
    fxpValue warmState, calcState;
    fxpValue warmNext, calcNext;
    // Control delayed by the read and tap-sum registers
    logic [1:0] endPipe, onPipe;

    lutTapSum lookTapSum (
        .clkDS(clkDS),
        .word(lookWord),
        .contrib(lookContrib)
    );

    lutTapSum calcTapSum (
        .clkDS(clkDS),
        .word(word),
        .contrib(calcContrib)
    );

    assign warmNext = poleProduct(feedBackward, warmState) + lookContrib;
    assign calcNext = poleProduct(feedBackward, calcState) + calcContrib;

    // At the delayed batch end the warm-up has taken its last word
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            endPipe <= '0;
            onPipe <= '0;
            warmState <= '0;
            calcState <= '0;
        end else begin
            endPipe <= {endPipe[0], ctrl.batchEnd};
            onPipe <= {onPipe[0], ctrl.computeOn};
            warmState <= endPipe[1] ? '0 : warmNext;
            if (endPipe[1]) begin
                calcState <= warmNext;
            end else if (onPipe[1]) begin
                calcState <= calcNext;
            end
        end
    end

    // Keeps the last word of a batch that the hand-over overwrites
    always_ff @(posedge clkDS) begin
        if (onPipe[1]) begin
            result <= calcNext;
        end
    end

endmodule

// File: verilog/batchCombiner.sv
`timescale 1ns/1ps
`include "batchEst_cfg.svh"

module batchCombiner (
    input  logic clkDS,
    input  logic rst,
    input  batchEstPkg::batchCtrl ctrl,
    input  batchEstPkg::fxpValue fwd,
    input  batchEstPkg::fxpValue bwd,
    output batchEstPkg::estimateWord estimate
);
    import batchEstPkg::*;

    localparam int OW = `BE_OUT_WIDTH;
    localparam int SHIFT = `BE_N_MANT - (OW - 1);
    // Read, tap sum, recursion and scaling registers
    localparam int RES_DELAY = 4;

    typedef logic signed [OW-1:0] outValue;
    typedef logic signed [$bits(fxpValue):0] wideValue;

    localparam wideValue OUT_MAX = wideValue'(2 ** (OW - 1) - 1);
    localparam wideValue OUT_MIN = -wideValue'(2 ** (OW - 1));

    batchCtrl ctrlPipe [RES_DELAY];
    outValue fwdScaled, bwdScaled, fwdRd, bwdRd;
    outValue fwdMem [2*`BE_DEPTH];
    outValue bwdMem [2*`BE_DEPTH];
    logic outOn, readOn;

    function automatic outValue saturate(wideValue x);
        if (x > OUT_MAX) begin
            return outValue'(OUT_MAX);
        end else if (x < OUT_MIN) begin
            return outValue'(OUT_MIN);
        end
        return outValue'(x);
    endfunction

    // Down to OW-1 fraction bits, round half up
    function automatic outValue toOutput(fxpValue x);
        wideValue w;
        w = x;
        w = (w + (1 << (SHIFT - 1))) >>> SHIFT;
        return saturate(w);
    endfunction

    function automatic outValue satAdd(outValue a, outValue b);
        wideValue s;
        s = wideValue'(a) + wideValue'(b);
        return saturate(s);
    endfunction

    // Write one result bank while the other is read in index order
    always_ff @(posedge clkDS) begin
        fwdScaled <= toOutput(fwd);
        bwdScaled <= toOutput(bwd);
        fwdMem[{ctrlPipe[RES_DELAY-1].resBank, ctrlPipe[RES_DELAY-1].idx}] <= fwdScaled;
        bwdMem[{ctrlPipe[RES_DELAY-1].resBank, ctrlPipe[RES_DELAY-1].idxRev}] <= bwdScaled;
        fwdRd <= fwdMem[{~ctrlPipe[RES_DELAY-1].resBank, ctrlPipe[RES_DELAY-1].idx}];
        bwdRd <= bwdMem[{~ctrlPipe[RES_DELAY-1].resBank, ctrlPipe[RES_DELAY-1].idx}];
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < RES_DELAY; s++) begin
                ctrlPipe[s] <= '0;
            end
            outOn <= 1'b0;
            readOn <= 1'b0;
            estimate <= '0;
        end else begin
            ctrlPipe[0] <= ctrl;
            for (int s = 1; s < RES_DELAY; s++) begin
                ctrlPipe[s] <= ctrlPipe[s-1];
            end
            // First fully computed bank is ready for reading
            if (ctrlPipe[RES_DELAY-1].batchEnd && ctrlPipe[RES_DELAY-1].computeOn) begin
                outOn <= 1'b1;
            end
            readOn <= outOn;
            // Offset binary: flip the sign bit
            estimate <= readOn ? (satAdd(fwdRd, bwdRd) ^ (1 << (OW - 1))) : '0;
        end
    end

endmodule

// File: verilog/batchEstimator.sv
`timescale 1ns/1ps

module batchEstimator (
    input  logic clkDS,
    input  logic rst,
    input  batchEstPkg::sampleWord sample,
    output batchEstPkg::estimateWord estimate,
    output logic valid
);
    import batchEstPkg::*;

    batchCtrl ctrl;
    sampleAddrs addrs;
    sampleWord lookWord, fwdWord, bwdWord;
    fxpValue fwdResult, bwdResult;

    batchControl control (
        .clkDS(clkDS),
        .rst(rst),
        .ctrl(ctrl),
        .addrs(addrs),
        .valid(valid)
    );

    sampleMemory sampleStore (
        .clkDS(clkDS),
        .addrs(addrs),
        .wrData(sample),
        .lookWord(lookWord),
        .fwdWord(fwdWord),
        .bwdWord(bwdWord)
    );

    forwardRecursion fwdRec (
        .clkDS(clkDS),
        .rst(rst),
        .ctrl(ctrl),
        .word(fwdWord),
        .result(fwdResult)
    );

    backwardRecursion bwdRec (
        .clkDS(clkDS),
        .rst(rst),
        .ctrl(ctrl),
        .lookWord(lookWord),
        .word(bwdWord),
        .result(bwdResult)
    );

    batchCombiner combiner (
        .clkDS(clkDS),
        .rst(rst),
        .ctrl(ctrl),
        .fwd(fwdResult),
        .bwd(bwdResult),
        .estimate(estimate)
    );

endmodule

// File: tests/batchEstimator_assert.sv
`timescale 1ns/1ps
`include "batchEst_cfg.svh"

module batchEstimatorAssert (
    input logic clkDS,
    input logic rst,
    input logic valid,
    input batchEstPkg::batchCtrl ctrl
);
    import batchEstPkg::*;

    // Read by the testbench summary
    int failCount = 0;

    validInReset: assert property (@(posedge clkDS) !rst |-> !valid)
        else begin
            failCount++;
            $error("valid high while reset is asserted");
        end

    banksDistinct: assert property (@(posedge clkDS) disable iff (!rst)
        ctrl.writeBank != ctrl.lookBank && ctrl.writeBank != ctrl.calcBank &&
        ctrl.lookBank != ctrl.calcBank)
        else begin
            failCount++;
            $error("bank roles overlap");
        end

    // One pulse, then the next one BE_DEPTH cycles later
    batchEndSingle: assert property (@(posedge clkDS) disable iff (!rst)
        ctrl.batchEnd |=> !ctrl.batchEnd)
        else begin
            failCount++;
            $error("batchEnd longer than one cycle");
        end

    batchEndPeriod: assert property (@(posedge clkDS) disable iff (!rst)
        ctrl.batchEnd |-> ##`BE_DEPTH ctrl.batchEnd)
        else begin
            failCount++;
            $error("batchEnd period is not BE_DEPTH");
        end

endmodule

bind batchEstimator batchEstimatorAssert assertInst (
    .clkDS(clkDS),
    .rst(rst),
    .valid(valid),
    .ctrl(ctrl)
);

// File: tests/batchEstimator_tb.sv
`timescale 1ns/1ps
`include "batchEst_cfg.svh"

module batchEstimator_tb;
    import batchEstPkg::*;

    localparam int LATENCY = 4 * `BE_DEPTH + `BE_PIPE;
    localparam int MAX_RECS = 64;
    localparam string STIM_FILE = "tests/batchEstimator_input.txt";

    // One run of identical cycles from the data file
    typedef struct packed {
        logic [15:0] count;
        logic [3:0] rstBit;
        sampleWord smp;
        sampleWord toggle;
        logic [3:0] validBit;
        logic [3:0] checkEst;
        logic [15:0] est;
    } stimRecord;

    logic clkDS;
    logic rst;
    sampleWord sample;
    estimateWord estimate;
    logic valid;

    logic [$bits(stimRecord)-1:0] recMem [MAX_RECS];
    int totalCycles = 0;
    int estErrors = 0;
    int validErrors = 0;
    bit runDone = 0;

    batchEstimator batchEstimator_inst (
        .clkDS(clkDS),
        .rst(rst),
        .sample(sample),
        .estimate(estimate),
        .valid(valid)
    );

    initial begin
        clkDS = 1'b0;
        forever #10 clkDS = ~clkDS;
    end

    task automatic checkEstimate(estimateWord expected, estimateWord actual);
        if (actual !== expected) begin
            estErrors++;
            $display("FAILED at %0t ns: estimate expected %h, got %h", $time, expected, actual);
        end
    endtask

    task automatic checkValid(logic expected, logic actual);
        if (actual !== expected) begin
            validErrors++;
            $display("FAILED at %0t ns: valid expected %b, got %b", $time, expected, actual);
        end
    endtask

    // Applies every cycle of the loaded runs and checks after the edge
    task automatic runRecords();
        stimRecord rec;
        int cyc;
        cyc = 0;
        for (int r = 0; r < MAX_RECS; r++) begin
            rec = stimRecord'(recMem[r]);
            if (rec.count == 0) begin
                break;
            end
            for (int n = 0; n < rec.count; n++) begin
                @(posedge clkDS);
                rst <= rec.rstBit[0];
                sample <= (cyc % 2 == 1) ? (rec.smp ^ rec.toggle) : rec.smp;
                @(negedge clkDS);
                checkValid(rec.validBit[0], valid);
                if (rec.checkEst[0]) begin
                    checkEstimate(estimateWord'(rec.est), estimate);
                end else if (!rec.validBit[0]) begin
                    // No estimate yet, output held at zero
                    checkEstimate('0, estimate);
                end
                cyc++;
            end
        end
    endtask

    initial begin
        int fd;
        int assertFails;
        stimRecord rec;
        rst = 1'b0;
        sample = '0;
        for (int r = 0; r < MAX_RECS; r++) begin
            recMem[r] = '0;
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Stimulus file %s could not be opened", STIM_FILE);
            $display("Test failed");
            $finish;
        end else begin
            $fclose(fd);
            $readmemh(STIM_FILE, recMem);
            for (int r = 0; r < MAX_RECS; r++) begin
                rec = stimRecord'(recMem[r]);
                totalCycles += rec.count;
            end
            runRecords();
            runDone = 1;
            assertFails = batchEstimator_inst.assertInst.failCount;
            $display("Errors: estimate %0d, valid %0d, assertion %0d",
                     estErrors, validErrors, assertFails);
            if (estErrors == 0 && validErrors == 0 && assertFails == 0 && totalCycles > 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // Ends a stuck run after all data lines plus one pipeline latency
    initial begin
        wait (totalCycles > 0);
        repeat (totalCycles + LATENCY) @(posedge clkDS);
        if (!runDone) begin
            $display("Timeout after %0d cycles, stimulus did not finish", totalCycles + LATENCY);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+verilog
verilog/batchEstPkg.sv
verilog/batchControl.sv
verilog/sampleMemory.sv
verilog/lutTapSum.sv
verilog/forwardRecursion.sv
verilog/backwardRecursion.sv
verilog/batchCombiner.sv
verilog/batchEstimator.sv
tests/batchEstimator_assert.sv
tests/batchEstimator_tb.sv

// File: tests/batchEstimator_input.txt
// count rst sample toggle validExp checkEst estimateExp, one run of cycles per line
// Sample is XORed with toggle on odd cycles; estimate checked only where checkEst is 1
// Alternating LSB stream, saturates high
0008_0_FF_01_0_1_0000
0026_1_FF_01_0_0_0000
0028_1_FF_01_1_1_3FFF
// Reset mid-run, then all ones
0008_0_FF_00_0_1_0000
0026_1_FF_00_0_0_0000
0028_1_FF_00_1_1_3FFF
// Reset, then all zeros, minimum code
0008_0_00_00_0_1_0000
0026_1_00_00_0_0_0000
0028_1_00_00_1_1_0000
// Reset, alternating LSB low stream
0008_0_00_01_0_1_0000
0026_1_00_01_0_0_0000
0028_1_00_01_1_1_0000
// Short reset pulse, valid latency again
0008_0_FF_00_0_1_0000
0026_1_FF_00_0_0_0000
0018_1_FF_00_1_1_3FFF
